//--- filelist.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_control.sv
hdl/pc_unit.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/fetch_top.sv
test/fetch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module fetch_tb -o fetch_sim &&
sim_out="$(obj_dir/fetch_sim)" ;
status=$? ;
echo "$sim_out" ;
[ "$status" -eq 0 ] &&
echo "$sim_out" | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed" ; exit 1 ; }

//--- test/fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_MARGIN = 20;            // spare cycles past the table
    localparam logic [31:0] SEED  = 32'ha6ec_26dd;

    // expectation mask bits
    localparam logic [3:0] M_V   = 4'b0001;        // fetch.valid
    localparam logic [3:0] M_P   = 4'b0010;        // fetch.pc
    localparam logic [3:0] M_I   = 4'b0100;        // fetch.instruction
    localparam logic [3:0] M_D   = 4'b1000;        // dmem_rdata
    localparam logic [3:0] M_VP  = M_V | M_P;
    localparam logic [3:0] M_VPI = M_V | M_P | M_I;
    localparam logic [3:0] M_ALL = M_V | M_P | M_I | M_D;

    // program words loaded to imem 0..7
    localparam logic [`FETCH_WORD_W-1:0] PROG [8] = '{
        32'h0010_0093, 32'h0020_0113, 32'h0020_81b3, 32'h0031_a023,
        32'h0001_a203, 32'hffc1_8193, 32'hfe01_9ce3, 32'h0000_006f
    };

    typedef struct packed {
        logic                        load_active;
        load_wr_t                    load_wr;
        logic                        hold;
        redirect_t                   redirect;
        logic [`FETCH_DMEM_AW-1:0]   dmem_addr;
        logic [3:0]                  mask;        // which expectations apply
        logic                        exp_valid;
        logic [`FETCH_WORD_W-1:0]    exp_pc;
        logic [`FETCH_WORD_W-1:0]    exp_instr;
        logic [`FETCH_WORD_W-1:0]    exp_dmem;
    } row_t;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      load_active;
    load_wr_t                  load_wr;
    logic                      hold;
    redirect_t                 redirect;
    logic [`FETCH_DMEM_AW-1:0] dmem_addr;
    fetch_out_t                fetch;
    logic [`FETCH_WORD_W-1:0]  dmem_rdata;

    row_t                      rows [$];
    logic [`FETCH_WORD_W-1:0]  dword [4];          // random dmem contents
    int                        cycle_count = 0;
    int                        timeout_limit;

    fetch_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_active (load_active),
        .load_wr     (load_wr),
        .hold        (hold),
        .redirect    (redirect),
        .dmem_addr   (dmem_addr),
        .fetch       (fetch),
        .dmem_rdata  (dmem_rdata)
    );

    always #10 clk = ~clk;                         // 20 ns period

    // run limit, sized once the table is built
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the table did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic add_row(
        input int la, input int we, input int addr, input logic [31:0] data,
        input int hld, input int off, input int jmp, input logic [31:0] value,
        input int daddr, input logic [3:0] mask, input int ev,
        input logic [31:0] epc, input logic [31:0] einstr, input logic [31:0] edmem
    );
        row_t r;
        r.load_active        = (la != 0);
        r.load_wr.we         = (we != 0);
        r.load_wr.addr       = `FETCH_LOAD_AW'(addr);
        r.load_wr.data       = data;
        r.hold               = (hld != 0);
        r.redirect.offset_en = (off != 0);
        r.redirect.jump_en   = (jmp != 0);
        r.redirect.value     = value;
        r.dmem_addr          = `FETCH_DMEM_AW'(daddr);
        r.mask               = mask;
        r.exp_valid          = (ev != 0);
        r.exp_pc             = epc;
        r.exp_instr          = einstr;
        r.exp_dmem           = edmem;
        rows.push_back(r);
    endtask

    // la we addr data | hold off jmp value | daddr | mask valid pc instr dmem
    task automatic build_table();
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 1, 0, 0, 0);       // free run from 0
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 1, 1, 0, 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 1, 2, 0, 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 1, 3, 0, 0);
        add_row(1, 1, 'h000, PROG[0], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0); // imem load, pc frozen
        add_row(1, 1, 'h001, PROG[1], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h002, PROG[2], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h003, PROG[3], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h004, PROG[4], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h005, PROG[5], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h006, PROG[6], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h007, PROG[7], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h102, dword[0], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0); // dmem half
        add_row(1, 1, 'h105, dword[1], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h107, dword[2], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(1, 1, 'h103, dword[3], 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);       // load falls
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 0, 3, 0, 0);       // restart cycle
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 2, M_ALL, 1, 0, PROG[0], dword[0]);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 5, M_ALL, 1, 1, PROG[1], dword[1]);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 7, M_ALL, 1, 2, PROG[2], dword[2]);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 3, M_ALL, 1, 3, PROG[3], dword[3]);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 4, PROG[4], 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 5, PROG[5], 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 6, PROG[6], 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 7, PROG[7], 0);
        add_row(0, 0, 'h000, 0, 0, 1, 0, 5, 0, M_VP, 1, 8, 0, 0);        // offset +5
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VP, 1, 13, 0, 0);
        add_row(0, 0, 'h000, 0, 0, 0, 1, 2, 0, M_VP, 1, 14, 0, 0);       // jump to 2+1
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 3, PROG[3], 0);
        add_row(0, 0, 'h000, 0, 0, 1, 1, 100, 0, M_VPI, 1, 4, PROG[4], 0); // both set
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 5, PROG[5], 0);
        add_row(0, 0, 'h000, 0, 0, 1, 0, -5, 0, M_VPI, 1, 6, PROG[6], 0);  // backward branch
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 1, PROG[1], 0);
        add_row(0, 0, 'h000, 0, 1, 0, 1, 7, 0, M_VPI, 0, 1, PROG[1], 0);   // held jump
        add_row(0, 0, 'h000, 0, 1, 1, 0, 3, 0, M_VPI, 0, 1, PROG[1], 0);   // held offset
        add_row(0, 1, 'h003, 32'hdead_beef, 0, 0, 0, 0, 0, M_VPI, 1, 2, PROG[2], 0);
        add_row(0, 1, 'h102, 32'h0bad_f00d, 0, 0, 0, 0, 0, M_VPI, 1, 3, PROG[3], 0);
        add_row(0, 0, 'h000, 0, 1, 0, 0, 0, 0, M_VPI, 0, 3, PROG[3], 0);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 4, PROG[4], 0);
        add_row(0, 0, 'h000, 0, 0, 0, 1, 0, 2, M_ALL, 1, 5, PROG[5], dword[0]);
        add_row(0, 0, 'h000, 0, 0, 0, 0, 0, 0, M_VPI, 1, 1, PROG[1], 0);
    endtask

    task automatic apply_row(input row_t r);
        load_active = r.load_active;
        load_wr     = r.load_wr;
        hold        = r.hold;
        redirect    = r.redirect;
        dmem_addr   = r.dmem_addr;
    endtask

    task automatic check_row(input row_t r, input int idx);
        if (r.mask[0])
            compare_word($sformatf("fetch.valid (row %0d)", idx), 32'(fetch.valid),
                         32'(r.exp_valid));
        if (r.mask[1])
            compare_word($sformatf("fetch.pc (row %0d)", idx), fetch.pc, r.exp_pc);
        if (r.mask[2])
            compare_word($sformatf("fetch.instruction (row %0d)", idx), fetch.instruction,
                         r.exp_instr);
        if (r.mask[3])
            compare_word($sformatf("dmem_rdata (row %0d)", idx), dmem_rdata, r.exp_dmem);
    endtask

    initial begin
        int k;
        rst_n       = 1'b0;
        load_active = 1'b0;
        load_wr     = '0;
        hold        = 1'b0;
        redirect    = '0;
        dmem_addr   = '0;
        void'($urandom(SEED));
        for (k = 0; k < 4; k++) begin
            dword[k] = $urandom();                 // words for the dmem half of the load
        end
        build_table();
        timeout_limit = rows.size() + RESET_CYCLES + TIMEOUT_MARGIN;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        compare_word("fetch.valid after reset", 32'(fetch.valid), 32'd0);
        apply_row(rows[0]);
        for (k = 0; k < rows.size(); k++) begin
            @(negedge clk);                        // results of row k settled
            check_row(rows[k], k);
            if (k + 1 < rows.size()) begin
                apply_row(rows[k + 1]);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_active, // boot unit streaming
    input  load_wr_t                  load_wr,
    input  logic                      hold,        // from hazard logic
    input  redirect_t                 redirect,    // from execute
    input  logic [`FETCH_DMEM_AW-1:0] dmem_addr,   // from memory stage
    output fetch_out_t                fetch,       // to decode
    output logic [`FETCH_WORD_W-1:0]  dmem_rdata
);

    mem_wr_t                  imem_wr;
    mem_wr_t                  dmem_wr;
    logic                     run_en;
    logic                     restart;
    logic [`FETCH_WORD_W-1:0] pc;
    logic [`FETCH_WORD_W-1:0] instr;
    logic [`FETCH_WORD_W-1:0] fetch_pc_q;  // pc of the word in instr
    logic                     valid_q;

    fetch_control i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_active (load_active),
        .load_wr     (load_wr),
        .hold        (hold),
        .imem_wr     (imem_wr),
        .dmem_wr     (dmem_wr),
        .run_en      (run_en),
        .restart     (restart)
    );

    pc_unit i_pc (
        .clk      (clk),
        .rst_n    (rst_n),
        .run_en   (run_en),
        .restart  (restart),
        .redirect (redirect),
        .pc       (pc)
    );

    instr_mem i_imem (
        .clk     (clk),
        .wr      (imem_wr),
        .rd_en   (run_en),                     // freezes instr under hold
        .rd_addr (pc[`FETCH_IMEM_AW-1:0]),     // word address
        .rd_data (instr)
    );

    data_mem i_dmem (
        .clk     (clk),
        .wr      (dmem_wr),
        .rd_addr (dmem_addr),
        .rd_data (dmem_rdata)
    );

    // match the imem read latency
    always_ff @(posedge clk) begin
        if (run_en) begin
            fetch_pc_q <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= run_en;                 // follows run_en even when frozen
        end
    end

    assign fetch.valid       = valid_q;
    assign fetch.pc          = fetch_pc_q;
    assign fetch.instruction = instr;

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module data_mem import fetch_pkg::*; (
    input  logic                      clk,
    input  mem_wr_t                   wr,      // loader port
    input  logic [`FETCH_DMEM_AW-1:0] rd_addr, // from memory stage
    output logic [`FETCH_WORD_W-1:0]  rd_data
);

    localparam int unsigned DEPTH = 1 << `FETCH_DMEM_AW;

    logic [`FETCH_WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;           // visible to the next read
        end
    end

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/instr_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module instr_mem import fetch_pkg::*; (
    input  logic                      clk,
    input  mem_wr_t                   wr,      // loader port
    input  logic                      rd_en,   // low keeps last word
    input  logic [`FETCH_IMEM_AW-1:0] rd_addr,
    output logic [`FETCH_WORD_W-1:0]  rd_data
);

    localparam int unsigned DEPTH = 1 << `FETCH_IMEM_AW;

    logic [`FETCH_WORD_W-1:0] mem [DEPTH];     // no reset, filled by loader

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/pc_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module pc_unit import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run_en,   // advance this cycle
    input  logic                     restart,  // back to start address
    input  redirect_t                redirect, // from execute
    output logic [`FETCH_WORD_W-1:0] pc
);

    logic [`FETCH_WORD_W-1:0] pc_next;
    logic [`FETCH_WORD_W-1:0] pc_inc;

    assign pc_inc = pc + `FETCH_WORD_W'd1;

    // both enables set is treated as no redirect
    always_comb begin
        case ({redirect.offset_en, redirect.jump_en})
            2'b10:   pc_next = pc + redirect.value;                // relative branch
            2'b01:   pc_next = redirect.value + `FETCH_WORD_W'd1;  // jump past target
            default: pc_next = pc_inc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            pc <= `FETCH_PC_RESET;             // restart wins over run_en
        end else if (run_en) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_control.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_cfg.svh"

module fetch_control import fetch_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_active, // boot unit streaming
    input  load_wr_t load_wr,
    input  logic     hold,        // hazard stall
    output mem_wr_t  imem_wr,
    output mem_wr_t  dmem_wr,
    output logic     run_en,
    output logic     restart      // one cycle, after load ends
);

    typedef enum logic {
        ST_RUN  = 1'b0,
        ST_LOAD = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   to_dmem;              // loader address in upper half
    logic   load_wr_ok;           // write accepted only while loading

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN:  if (load_active) state_d = ST_LOAD;   // rising edge of load
            ST_LOAD: if (!load_active) state_d = ST_RUN;   // falling edge, back to fetch
            default: state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_RUN;
            restart <= 1'b0;
        end else begin
            state_q <= state_d;
            restart <= (state_q == ST_LOAD) && !load_active; // pulse after fall
        end
    end

    assign to_dmem    = load_wr.addr[`FETCH_LOAD_AW-1];
    assign load_wr_ok = load_wr.we && load_active;

    // same address and data to both, strobe decides
    always_comb begin
        imem_wr.we   = load_wr_ok && !to_dmem;
        imem_wr.addr = load_wr.addr[`FETCH_IMEM_AW-1:0];
        imem_wr.data = load_wr.data;
        dmem_wr.we   = load_wr_ok && to_dmem;
        dmem_wr.addr = load_wr.addr[`FETCH_DMEM_AW-1:0];
        dmem_wr.data = load_wr.data;
    end

    // restart cycle reloads the pc, so no fetch then
    assign run_en = (state_q == ST_RUN) && !load_active && !hold && !restart;

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    typedef struct packed {
        logic                        we;          // one-cycle pulse per word
        logic [`FETCH_LOAD_AW-1:0]   addr;        // msb selects dmem
        logic [`FETCH_WORD_W-1:0]    data;
    } load_wr_t;

    typedef struct packed {
        logic                        we;
        logic [`FETCH_IMEM_AW-1:0]   addr;        // dmem has the same width
        logic [`FETCH_WORD_W-1:0]    data;
    } mem_wr_t;

    typedef struct packed {
        logic                        offset_en;   // pc + value
        logic                        jump_en;     // value + 1
        logic [`FETCH_WORD_W-1:0]    value;
    } redirect_t;

    typedef struct packed {
        logic                        valid;
        logic [`FETCH_WORD_W-1:0]    pc;
        logic [`FETCH_WORD_W-1:0]    instruction; // word stored at pc
    } fetch_out_t;

endpackage

`default_nettype wire

//--- include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// datapath word, shared by instructions, data and the pc
`define FETCH_WORD_W 32

// word addresses, one word per entry
`define FETCH_IMEM_AW 8
`define FETCH_DMEM_AW 8

// loader address, top bit picks the memory
`define FETCH_LOAD_AW 9

// start address after reset or after a load
`define FETCH_PC_RESET 32'd0

`endif
